// ==== tb.f ====
+incdir+include
verilog/dispatch_pkg.sv
verilog/fwd_if.sv
verilog/issue_select.sv
verilog/reg_scoreboard.sv
verilog/operand_forward.sv
verilog/dispatch_reg.sv
verilog/dispatch_top.sv
dv/dispatch_asserts.sv
dv/dispatch_checker.sv
dv/tb_top.sv

// ==== dv/tb_top.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module tb_top
    import dispatch_pkg::*;
();

    logic                                         clk;
    logic                                         rst_n;
    logic                                         stall;
    logic                                         flush;
    integer                                       seed;
    id_slot_t [`DISP_WIDTH-1:0]                   id_slots;
    fwd_entry_t [`DISP_WIDTH-1:0]                 ex_ent;
    fwd_entry_t [`DISP_WIDTH-1:0]                 wb_ent;
    logic [`DISP_WIDTH-1:0][1:0][`GPR_ADDR_W-1:0] rf_raddr;
    logic [`DISP_WIDTH-1:0][1:0][`DATA_W-1:0]     rf_rdata;
    logic [`DISP_WIDTH-1:0]                       ib_accept;
    logic [`DISP_WIDTH-1:0]                       exe_valid;
    logic [`DISP_WIDTH-1:0][`PC_W-1:0]            exe_pc;
    logic [`DISP_WIDTH-1:0][`OP_W-1:0]            exe_op;
    logic [`DISP_WIDTH-1:0][`DATA_W-1:0]          exe_src1;
    logic [`DISP_WIDTH-1:0][`DATA_W-1:0]          exe_src2;
    logic [`DISP_WIDTH-1:0][`GPR_ADDR_W-1:0]      exe_rd_addr;
    logic [`DISP_WIDTH-1:0]                       exe_rd_valid;
    logic [`DISP_WIDTH-1:0]                       exe_is_load;
    int                                           err_cnt;
    int                                           chk_cnt;
    bit                                           timed_out;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Register file answers with a scramble of the whole address
    function automatic logic [`DATA_W-1:0] rf_value(input logic [`GPR_ADDR_W-1:0] a);
        return {a, 3'b101, ~a, 3'b010, a, a, 6'h2d};
    endfunction

    always_comb begin
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            for (int j = 0; j < 2; j++) begin
                rf_rdata[s][j] = rf_value(rf_raddr[s][j]);
            end
        end
    end

    dispatch_top uut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .stall_i             (stall),
        .flush_i             (flush),
        .id_valid_i          ({id_slots[1].valid, id_slots[0].valid}),
        .id_pc_i             ({id_slots[1].pc, id_slots[0].pc}),
        .id_op_i             ({id_slots[1].op, id_slots[0].op}),
        .id_is_load_i        ({id_slots[1].is_load, id_slots[0].is_load}),
        .id_is_store_i       ({id_slots[1].is_store, id_slots[0].is_store}),
        .id_rs_addr_i        ({id_slots[1].rs_addr, id_slots[0].rs_addr}),
        .id_rs_valid_i       ({id_slots[1].rs_valid, id_slots[0].rs_valid}),
        .id_rd_addr_i        ({id_slots[1].rd_addr, id_slots[0].rd_addr}),
        .id_rd_valid_i       ({id_slots[1].rd_valid, id_slots[0].rd_valid}),
        .id_use_imm_i        ({id_slots[1].use_imm, id_slots[0].use_imm}),
        .id_imm_i            ({id_slots[1].imm, id_slots[0].imm}),
        .rf_raddr_o          (rf_raddr),
        .rf_rdata_i          (rf_rdata),
        .ex_fwd_wr_i         ({ex_ent[1].wr, ex_ent[0].wr}),
        .ex_fwd_addr_i       ({ex_ent[1].addr, ex_ent[0].addr}),
        .ex_fwd_data_i       ({ex_ent[1].data, ex_ent[0].data}),
        .ex_fwd_data_valid_i ({ex_ent[1].data_valid, ex_ent[0].data_valid}),
        .wb_fwd_wr_i         ({wb_ent[1].wr, wb_ent[0].wr}),
        .wb_fwd_addr_i       ({wb_ent[1].addr, wb_ent[0].addr}),
        .wb_fwd_data_i       ({wb_ent[1].data, wb_ent[0].data}),
        .wb_fwd_data_valid_i ({wb_ent[1].data_valid, wb_ent[0].data_valid}),
        .ib_accept_o         (ib_accept),
        .exe_valid_o         (exe_valid),
        .exe_pc_o            (exe_pc),
        .exe_op_o            (exe_op),
        .exe_src1_o          (exe_src1),
        .exe_src2_o          (exe_src2),
        .exe_rd_addr_o       (exe_rd_addr),
        .exe_rd_valid_o      (exe_rd_valid),
        .exe_is_load_o       (exe_is_load)
    );

    dispatch_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_i        (stall),
        .flush_i        (flush),
        .slots_i        (id_slots),
        .ex_ent_i       (ex_ent),
        .wb_ent_i       (wb_ent),
        .rf_raddr_i     (rf_raddr),
        .rf_rdata_i     (rf_rdata),
        .ib_accept_i    (ib_accept),
        .exe_valid_i    (exe_valid),
        .exe_pc_i       (exe_pc),
        .exe_op_i       (exe_op),
        .exe_src1_i     (exe_src1),
        .exe_src2_i     (exe_src2),
        .exe_rd_addr_i  (exe_rd_addr),
        .exe_rd_valid_i (exe_rd_valid),
        .exe_is_load_i  (exe_is_load),
        .err_cnt_o      (err_cnt),
        .chk_cnt_o      (chk_cnt)
    );

    bind dispatch_top dispatch_asserts u_asserts (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .ib_accept_i (ib_accept_o),
        .exe_valid_i (exe_valid_o)
    );

    function automatic int total_errors();
        return err_cnt + uut.u_asserts.fail_cnt;
    endfunction

    // Test 2 splits sources from destinations and later tests crowd a few registers
    function automatic logic [`GPR_ADDR_W-1:0] pick_addr(
        input int                     mode,
        input logic [`GPR_ADDR_W-1:0] raw,
        input logic                   upper
    );
        if (mode == 2) begin
            return {upper, raw[3:0]};
        end
        if (mode >= 3) begin
            return {2'b00, raw[2:0]};
        end
        return raw;
    endfunction

    task automatic drive_cycle(input int mode);
        id_slot_t [`DISP_WIDTH-1:0]   s;
        fwd_entry_t [`DISP_WIDTH-1:0] ex;
        fwd_entry_t [`DISP_WIDTH-1:0] wb;
        logic [31:0]                  r;
        logic [31:0]                  q;
        logic [31:0]                  f;
        logic [31:0]                  g;
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            r = $random(seed);
            q = $random(seed);
            f = $random(seed);
            s[i].valid      = (mode == 2) || ((mode != 1) && (r[1:0] != 2'b00));
            s[i].pc         = $random(seed);
            s[i].op         = r[15:8];
            s[i].is_load    = (mode == 3 || mode >= 5) && r[2] && r[3];
            s[i].is_store   = (mode == 3) && r[4] && r[5];
            s[i].rs_addr[0] = pick_addr(mode, q[4:0], 1'b0);
            s[i].rs_addr[1] = pick_addr(mode, q[9:5], 1'b0);
            s[i].rs_valid   = q[16:15];
            s[i].rd_addr    = pick_addr(mode, q[14:10], 1'b1);
            s[i].rd_valid   = q[17] || (mode == 2);
            s[i].use_imm    = (mode >= 4) && q[18];
            s[i].imm        = $random(seed);
            // Fewer results come back in test 5, so loads stay pending longer
            ex[i].wr         = (mode >= 3) && f[0] && (mode != 5 || f[1]);
            ex[i].addr       = pick_addr(mode, f[6:2], f[7]);
            ex[i].data       = $random(seed);
            ex[i].data_valid = (f[9:8] != 2'b00);
            wb[i].wr         = (mode >= 3) && f[16] && (mode != 5 || f[17]);
            wb[i].addr       = pick_addr(mode, f[22:18], f[23]);
            wb[i].data       = $random(seed);
            wb[i].data_valid = (f[25:24] != 2'b00);
        end
        g = $random(seed);
        @(posedge clk);
        id_slots <= s;
        ex_ent   <= ex;
        wb_ent   <= wb;
        stall    <= (mode == 6) && (g[1:0] == 2'b00);
        flush    <= (mode == 6) && (g[4:2] == 3'b000);
    endtask

    // Runs at least the given cycles and, if asked, until slot 0 reaches execute
    task automatic run_test(
        input int    num,
        input string name,
        input int    cycles,
        input bit    need_issue
    );
        int err_start;
        int errs;
        int n;
        bit seen;
        err_start = total_errors();
        n = 0;
        seen = !need_issue;
        while ((n < cycles || !seen) && !timed_out) begin
            drive_cycle(num);
            @(negedge clk);
            if (exe_valid[0]) begin
                seen = 1'b1;
            end
            n++;
            if (!seen && n >= cycles + 200) begin
                timed_out = 1'b1;
                $display("test %0d timed out: no instruction reached execute", num);
            end
        end
        errs = total_errors() - err_start;
        $display("test %0d %s: %0d cycles, %0d errors, %s", num, name, n, errs,
                 (errs == 0 && !timed_out) ? "ok" : "failed");
    endtask

    initial begin
        seed      = 32'h00682fd6;
        rst_n     = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        id_slots  = '0;
        ex_ent    = '0;
        wb_ent    = '0;
        timed_out = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        run_test(1, "reset and idle accept", 20, 1'b0);
        if (!timed_out) begin
            run_test(2, "independent pair", 40, 1'b1);
        end
        if (!timed_out) begin
            run_test(3, "memory ops and pair dependency", 200, 1'b1);
        end
        if (!timed_out) begin
            run_test(4, "forwarding and immediates", 200, 1'b1);
        end
        if (!timed_out) begin
            run_test(5, "load blocking", 300, 1'b1);
        end
        if (!timed_out) begin
            run_test(6, "stall and flush", 300, 1'b1);
        end

        $display("summary: %0d checks, %0d checker errors, %0d assertion failures",
                 chk_cnt, err_cnt, uut.u_asserts.fail_cnt);
        if (total_errors() == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/dispatch_checker.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch_checker
    import dispatch_pkg::*;
(
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         stall_i,
    input  logic                                         flush_i,
    input  id_slot_t [`DISP_WIDTH-1:0]                   slots_i,
    input  fwd_entry_t [`DISP_WIDTH-1:0]                 ex_ent_i,
    input  fwd_entry_t [`DISP_WIDTH-1:0]                 wb_ent_i,
    input  logic [`DISP_WIDTH-1:0][1:0][`GPR_ADDR_W-1:0] rf_raddr_i,
    input  logic [`DISP_WIDTH-1:0][1:0][`DATA_W-1:0]     rf_rdata_i,
    input  logic [`DISP_WIDTH-1:0]                       ib_accept_i,
    input  logic [`DISP_WIDTH-1:0]                       exe_valid_i,
    input  logic [`DISP_WIDTH-1:0][`PC_W-1:0]            exe_pc_i,
    input  logic [`DISP_WIDTH-1:0][`OP_W-1:0]            exe_op_i,
    input  logic [`DISP_WIDTH-1:0][`DATA_W-1:0]          exe_src1_i,
    input  logic [`DISP_WIDTH-1:0][`DATA_W-1:0]          exe_src2_i,
    input  logic [`DISP_WIDTH-1:0][`GPR_ADDR_W-1:0]      exe_rd_addr_i,
    input  logic [`DISP_WIDTH-1:0]                       exe_rd_valid_i,
    input  logic [`DISP_WIDTH-1:0]                       exe_is_load_i,
    output int                                           err_cnt_o,
    output int                                           chk_cnt_o
);

    // Model state is the pending-load map and the pair expected in execute
    logic [`GPR_NUM-1:0]         avail_m;
    exe_slot_t [`DISP_WIDTH-1:0] exp_exe;

    initial begin
        err_cnt_o = 0;
        chk_cnt_o = 0;
        avail_m   = '1;
        exp_exe   = '0;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt_o++;
        if (act !== exp) begin
            err_cnt_o++;
            $display("ERR %s expected %0h actual %0h at %0t", name, exp, act, $time);
        end
    endtask

    // Search from ex slot 1 down to wb slot 0
    function automatic logic [`DATA_W-1:0] expect_operand(
        input logic [`GPR_ADDR_W-1:0] a,
        input logic [`DATA_W-1:0]     rf
    );
        if (a == '0) begin
            return '0;
        end
        for (int i = `DISP_WIDTH - 1; i >= 0; i--) begin
            if (ex_ent_i[i].wr && ex_ent_i[i].addr == a) begin
                return ex_ent_i[i].data;
            end
        end
        for (int i = `DISP_WIDTH - 1; i >= 0; i--) begin
            if (wb_ent_i[i].wr && wb_ent_i[i].addr == a) begin
                return wb_ent_i[i].data;
            end
        end
        return rf;
    endfunction

    // Inputs have settled since the rising edge and outputs show the last edge
    always @(negedge clk) begin : model_step
        logic                   single;
        logic                   dep;
        logic [`DISP_WIDTH-1:0] iss;
        logic [`DISP_WIDTH-1:0] acc;
        if (rst_n === 1'b1) begin
            for (int s = 0; s < `DISP_WIDTH; s++) begin
                compare($sformatf("exe_valid_o[%0d]", s), exp_exe[s].valid, exe_valid_i[s]);
                compare($sformatf("exe_pc_o[%0d]", s), exp_exe[s].pc, exe_pc_i[s]);
                compare($sformatf("exe_op_o[%0d]", s), exp_exe[s].op, exe_op_i[s]);
                compare($sformatf("exe_src1_o[%0d]", s), exp_exe[s].src1, exe_src1_i[s]);
                compare($sformatf("exe_src2_o[%0d]", s), exp_exe[s].src2, exe_src2_i[s]);
                compare($sformatf("exe_rd_addr_o[%0d]", s), exp_exe[s].rd_addr,
                        exe_rd_addr_i[s]);
                compare($sformatf("exe_rd_valid_o[%0d]", s), exp_exe[s].rd_valid,
                        exe_rd_valid_i[s]);
                compare($sformatf("exe_is_load_o[%0d]", s), exp_exe[s].is_load,
                        exe_is_load_i[s]);
            end
        end

        single = slots_i[0].is_load || slots_i[0].is_store ||
                 slots_i[1].is_load || slots_i[1].is_store;
        dep = slots_i[0].rd_valid &&
              ((slots_i[1].rs_valid[0] && slots_i[1].rs_addr[0] == slots_i[0].rd_addr) ||
               (slots_i[1].rs_valid[1] && slots_i[1].rs_addr[1] == slots_i[0].rd_addr));
        iss[0] = slots_i[0].valid && avail_m[slots_i[0].rs_addr[0]] &&
                 avail_m[slots_i[0].rs_addr[1]];
        iss[1] = iss[0] && slots_i[1].valid && !single && !dep &&
                 avail_m[slots_i[1].rs_addr[0]] && avail_m[slots_i[1].rs_addr[1]];
        acc[0] = !stall_i && (iss[0] || !slots_i[0].valid);
        acc[1] = !stall_i && (iss[1] || (!slots_i[1].valid && acc[0]));

        if (rst_n === 1'b1) begin
            compare("ib_accept_o", acc, ib_accept_i);
            for (int s = 0; s < `DISP_WIDTH; s++) begin
                for (int j = 0; j < 2; j++) begin
                    compare($sformatf("rf_raddr_o[%0d][%0d]", s, j), slots_i[s].rs_addr[j],
                            rf_raddr_i[s][j]);
                end
            end
        end

        // State after the coming rising edge
        if (rst_n !== 1'b1 || flush_i) begin
            avail_m = '1;
            exp_exe = '0;
        end else begin
            if (!stall_i) begin
                for (int s = 0; s < `DISP_WIDTH; s++) begin
                    exp_exe[s] = '0;
                    if (iss[s]) begin
                        exp_exe[s].valid    = 1'b1;
                        exp_exe[s].pc       = slots_i[s].pc;
                        exp_exe[s].op       = slots_i[s].op;
                        exp_exe[s].src1     = expect_operand(slots_i[s].rs_addr[0],
                                                             rf_rdata_i[s][0]);
                        exp_exe[s].src2     = slots_i[s].use_imm ? slots_i[s].imm :
                                              expect_operand(slots_i[s].rs_addr[1],
                                                             rf_rdata_i[s][1]);
                        exp_exe[s].rd_addr  = slots_i[s].rd_addr;
                        exp_exe[s].rd_valid = slots_i[s].rd_valid;
                        exp_exe[s].is_load  = slots_i[s].is_load;
                    end
                end
            end
            for (int i = 0; i < `DISP_WIDTH; i++) begin
                if (wb_ent_i[i].wr) begin
                    avail_m[wb_ent_i[i].addr] = wb_ent_i[i].data_valid;
                end
            end
            for (int i = 0; i < `DISP_WIDTH; i++) begin
                if (ex_ent_i[i].wr) begin
                    avail_m[ex_ent_i[i].addr] = ex_ent_i[i].data_valid;
                end
            end
            for (int i = 0; i < `DISP_WIDTH; i++) begin
                if (iss[i] && !stall_i && slots_i[i].is_load && slots_i[i].rd_valid) begin
                    avail_m[slots_i[i].rd_addr] = 1'b0;
                end
            end
            avail_m[0] = 1'b1;
        end
    end

endmodule

// ==== dv/dispatch_asserts.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   stall_i,
    input logic                   flush_i,
    input logic [`DISP_WIDTH-1:0] ib_accept_i,
    input logic [`DISP_WIDTH-1:0] exe_valid_i
);

    int fail_cnt = 0;

    // Instruction buffer keeps its slots while stalled
    a_no_accept_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall_i |-> (ib_accept_i == '0)
    ) else begin
        fail_cnt++;
        $error("instruction buffer accept raised during a stall");
    end

    // Pair stays in program order
    a_slot_order: assert property (
        @(posedge clk) disable iff (!rst_n) exe_valid_i[1] |-> exe_valid_i[0]
    ) else begin
        fail_cnt++;
        $error("slot 1 valid in execute without slot 0");
    end

    a_flush_clears: assert property (
        @(posedge clk) disable iff (!rst_n) flush_i |=> (exe_valid_i == '0)
    ) else begin
        fail_cnt++;
        $error("execute valid still set after a flush");
    end

endmodule

// ==== verilog/dispatch_top.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch_top
    import dispatch_pkg::*;
(
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         stall_i,
    input  logic                                         flush_i,
    input  logic [`DISP_WIDTH-1:0]                       id_valid_i,
    input  logic [`DISP_WIDTH-1:0][`PC_W-1:0]            id_pc_i,
    input  logic [`DISP_WIDTH-1:0][`OP_W-1:0]            id_op_i,
    input  logic [`DISP_WIDTH-1:0]                       id_is_load_i,
    input  logic [`DISP_WIDTH-1:0]                       id_is_store_i,
    input  logic [`DISP_WIDTH-1:0][1:0][`GPR_ADDR_W-1:0] id_rs_addr_i,
    input  logic [`DISP_WIDTH-1:0][1:0]                  id_rs_valid_i,
    input  logic [`DISP_WIDTH-1:0][`GPR_ADDR_W-1:0]      id_rd_addr_i,
    input  logic [`DISP_WIDTH-1:0]                       id_rd_valid_i,
    input  logic [`DISP_WIDTH-1:0]                       id_use_imm_i,
    input  logic [`DISP_WIDTH-1:0][`DATA_W-1:0]          id_imm_i,
    output logic [`DISP_WIDTH-1:0][1:0][`GPR_ADDR_W-1:0] rf_raddr_o,
    input  logic [`DISP_WIDTH-1:0][1:0][`DATA_W-1:0]     rf_rdata_i,
    input  logic [`DISP_WIDTH-1:0]                       ex_fwd_wr_i,
    input  logic [`DISP_WIDTH-1:0][`GPR_ADDR_W-1:0]      ex_fwd_addr_i,
    input  logic [`DISP_WIDTH-1:0][`DATA_W-1:0]          ex_fwd_data_i,
    input  logic [`DISP_WIDTH-1:0]                       ex_fwd_data_valid_i,
    input  logic [`DISP_WIDTH-1:0]                       wb_fwd_wr_i,
    input  logic [`DISP_WIDTH-1:0][`GPR_ADDR_W-1:0]      wb_fwd_addr_i,
    input  logic [`DISP_WIDTH-1:0][`DATA_W-1:0]          wb_fwd_data_i,
    input  logic [`DISP_WIDTH-1:0]                       wb_fwd_data_valid_i,
    output logic [`DISP_WIDTH-1:0]                       ib_accept_o,
    output logic [`DISP_WIDTH-1:0]                       exe_valid_o,
    output logic [`DISP_WIDTH-1:0][`PC_W-1:0]            exe_pc_o,
    output logic [`DISP_WIDTH-1:0][`OP_W-1:0]            exe_op_o,
    output logic [`DISP_WIDTH-1:0][`DATA_W-1:0]          exe_src1_o,
    output logic [`DISP_WIDTH-1:0][`DATA_W-1:0]          exe_src2_o,
    output logic [`DISP_WIDTH-1:0][`GPR_ADDR_W-1:0]      exe_rd_addr_o,
    output logic [`DISP_WIDTH-1:0]                       exe_rd_valid_o,
    output logic [`DISP_WIDTH-1:0]                       exe_is_load_o
);

    id_slot_t [`DISP_WIDTH-1:0]               slots;
    exe_slot_t [`DISP_WIDTH-1:0]              exe;
    logic [`GPR_NUM-1:0]                      avail;
    logic [`DISP_WIDTH-1:0]                   issue;
    logic [`DISP_WIDTH-1:0][1:0][`DATA_W-1:0] src;

    fwd_if ex_fwd ();
    fwd_if wb_fwd ();

    // Gather per-slot ports into structs
    always_comb begin
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            slots[s].valid    = id_valid_i[s];
            slots[s].pc       = id_pc_i[s];
            slots[s].op       = id_op_i[s];
            slots[s].is_load  = id_is_load_i[s];
            slots[s].is_store = id_is_store_i[s];
            slots[s].rs_addr  = id_rs_addr_i[s];
            slots[s].rs_valid = id_rs_valid_i[s];
            slots[s].rd_addr  = id_rd_addr_i[s];
            slots[s].rd_valid = id_rd_valid_i[s];
            slots[s].use_imm  = id_use_imm_i[s];
            slots[s].imm      = id_imm_i[s];

            ex_fwd.ent[s] = {ex_fwd_wr_i[s], ex_fwd_addr_i[s], ex_fwd_data_i[s],
                             ex_fwd_data_valid_i[s]};
            wb_fwd.ent[s] = {wb_fwd_wr_i[s], wb_fwd_addr_i[s], wb_fwd_data_i[s],
                             wb_fwd_data_valid_i[s]};
        end
    end

    issue_select u_issue_select (
        .slots_i  (slots),
        .avail_i  (avail),
        .stall_i  (stall_i),
        .issue_o  (issue),
        .accept_o (ib_accept_o)
    );

    reg_scoreboard u_reg_scoreboard (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .stall_i (stall_i),
        .ex_fwd  (ex_fwd),
        .wb_fwd  (wb_fwd),
        .slots_i (slots),
        .issue_i (issue),
        .avail_o (avail)
    );

    operand_forward u_operand_forward (
        .ex_fwd     (ex_fwd),
        .wb_fwd     (wb_fwd),
        .slots_i    (slots),
        .rf_rdata_i (rf_rdata_i),
        .rf_raddr_o (rf_raddr_o),
        .src_o      (src)
    );

    dispatch_reg u_dispatch_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .stall_i (stall_i),
        .slots_i (slots),
        .src_i   (src),
        .issue_i (issue),
        .exe_o   (exe)
    );

    // Spread the execute pair back onto plain ports
    always_comb begin
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            exe_valid_o[s]    = exe[s].valid;
            exe_pc_o[s]       = exe[s].pc;
            exe_op_o[s]       = exe[s].op;
            exe_src1_o[s]     = exe[s].src1;
            exe_src2_o[s]     = exe[s].src2;
            exe_rd_addr_o[s]  = exe[s].rd_addr;
            exe_rd_valid_o[s] = exe[s].rd_valid;
            exe_is_load_o[s]  = exe[s].is_load;
        end
    end

endmodule

// ==== verilog/dispatch_reg.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch_reg
    import dispatch_pkg::*;
(
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     flush_i,
    input  logic                                     stall_i,
    input  id_slot_t [`DISP_WIDTH-1:0]               slots_i,
    input  logic [`DISP_WIDTH-1:0][1:0][`DATA_W-1:0] src_i,
    input  logic [`DISP_WIDTH-1:0]                   issue_i,
    output exe_slot_t [`DISP_WIDTH-1:0]              exe_o
);

    exe_slot_t [`DISP_WIDTH-1:0] exe_d;

    // Next execute pair with bubbles where a slot did not issue
    always_comb begin
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            exe_d[s] = '0;
            if (issue_i[s]) begin
                exe_d[s].valid    = 1'b1;
                exe_d[s].pc       = slots_i[s].pc;
                exe_d[s].op       = slots_i[s].op;
                exe_d[s].src1     = src_i[s][0];
                exe_d[s].src2     = src_i[s][1];
                exe_d[s].rd_addr  = slots_i[s].rd_addr;
                exe_d[s].rd_valid = slots_i[s].rd_valid;
                exe_d[s].is_load  = slots_i[s].is_load;
            end
        end
    end

    // Flush beats stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_o <= '0;
        end else if (flush_i) begin
            exe_o <= '0;
        end else if (!stall_i) begin
            exe_o <= exe_d;
        end
    end

endmodule

// ==== verilog/operand_forward.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module operand_forward
    import dispatch_pkg::*;
(
    fwd_if.dst                                           ex_fwd,
    fwd_if.dst                                           wb_fwd,
    input  id_slot_t [`DISP_WIDTH-1:0]                   slots_i,
    input  logic [`DISP_WIDTH-1:0][1:0][`DATA_W-1:0]     rf_rdata_i,
    output logic [`DISP_WIDTH-1:0][1:0][`GPR_ADDR_W-1:0] rf_raddr_o,
    output logic [`DISP_WIDTH-1:0][1:0][`DATA_W-1:0]     src_o
);

    // Override base with the last matching entry, so slot 1 wins
    function automatic logic [`DATA_W-1:0] fwd_pick(
        input fwd_entry_t [`DISP_WIDTH-1:0] ent,
        input logic [`GPR_ADDR_W-1:0]       addr,
        input logic [`DATA_W-1:0]           base
    );
        logic [`DATA_W-1:0] val;
        val = base;
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            if (ent[i].wr && ent[i].addr == addr) begin
                val = ent[i].data;
            end
        end
        return val;
    endfunction

    always_comb begin
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            for (int j = 0; j < 2; j++) begin
                rf_raddr_o[s][j] = slots_i[s].rs_addr[j];
                // Register file, then wb, then ex
                src_o[s][j] = fwd_pick(ex_fwd.ent, slots_i[s].rs_addr[j],
                                       fwd_pick(wb_fwd.ent, slots_i[s].rs_addr[j],
                                                rf_rdata_i[s][j]));
                if (slots_i[s].rs_addr[j] == '0) begin
                    src_o[s][j] = '0;
                end
            end
            // Immediate replaces the second operand
            if (slots_i[s].use_imm) begin
                src_o[s][1] = slots_i[s].imm;
            end
        end
    end

endmodule

// ==== verilog/reg_scoreboard.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module reg_scoreboard
    import dispatch_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush_i,
    input  logic                       stall_i,
    fwd_if.dst                         ex_fwd,
    fwd_if.dst                         wb_fwd,
    input  id_slot_t [`DISP_WIDTH-1:0] slots_i,
    input  logic [`DISP_WIDTH-1:0]     issue_i,
    output logic [`GPR_NUM-1:0]        avail_o
);

    logic [`GPR_NUM-1:0] avail_q;

    // Later updates in this block override earlier ones
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            avail_q <= '1;
        end else if (flush_i) begin
            avail_q <= '1;
        end else begin
            // Oldest stage first
            for (int i = 0; i < `DISP_WIDTH; i++) begin
                if (wb_fwd.ent[i].wr) begin
                    avail_q[wb_fwd.ent[i].addr] <= wb_fwd.ent[i].data_valid;
                end
            end
            for (int i = 0; i < `DISP_WIDTH; i++) begin
                if (ex_fwd.ent[i].wr) begin
                    avail_q[ex_fwd.ent[i].addr] <= ex_fwd.ent[i].data_valid;
                end
            end
            // A load leaving dispatch makes its target pending
            for (int i = 0; i < `DISP_WIDTH; i++) begin
                if (issue_i[i] && !stall_i && slots_i[i].is_load && slots_i[i].rd_valid) begin
                    avail_q[slots_i[i].rd_addr] <= 1'b0;
                end
            end
            // r0 never waits
            avail_q[0] <= 1'b1;
        end
    end

    assign avail_o = avail_q;

endmodule

// ==== verilog/issue_select.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module issue_select
    import dispatch_pkg::*;
(
    input  id_slot_t [`DISP_WIDTH-1:0] slots_i,
    input  logic [`GPR_NUM-1:0]        avail_i,
    input  logic                       stall_i,
    output logic [`DISP_WIDTH-1:0]     issue_o,
    output logic [`DISP_WIDTH-1:0]     accept_o
);

    logic                   single;
    logic                   dep;
    logic [`DISP_WIDTH-1:0] ready;

    // Memory ops go alone
    assign single = slots_i[0].is_load | slots_i[0].is_store |
                    slots_i[1].is_load | slots_i[1].is_store;

    // Slot 1 reading what slot 0 writes
    always_comb begin
        dep = 1'b0;
        for (int j = 0; j < 2; j++) begin
            if (slots_i[1].rs_valid[j] && slots_i[0].rd_valid &&
                slots_i[1].rs_addr[j] == slots_i[0].rd_addr) begin
                dep = 1'b1;
            end
        end
    end

    // Both source registers must be free of pending loads
    always_comb begin
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            ready[s] = avail_i[slots_i[s].rs_addr[0]] & avail_i[slots_i[s].rs_addr[1]];
        end
    end

    // Slot 1 never issues ahead of slot 0
    assign issue_o[0] = slots_i[0].valid & ready[0];
    assign issue_o[1] = issue_o[0] & slots_i[1].valid & ~single & ~dep & ready[1];

    // Instruction buffer drops accepted slots
    assign accept_o[0] = ~stall_i & (issue_o[0] | ~slots_i[0].valid);
    assign accept_o[1] = ~stall_i & (issue_o[1] | (~slots_i[1].valid & accept_o[0]));

endmodule

// ==== verilog/fwd_if.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

interface fwd_if
    import dispatch_pkg::*;
();

    // One entry per slot of the producing stage
    fwd_entry_t [`DISP_WIDTH-1:0] ent;

    // Stage side
    modport src (output ent);

    // Dispatch side
    modport dst (input ent);

endinterface

// ==== verilog/dispatch_pkg.sv ====
`include "dispatch_cfg.svh"

package dispatch_pkg;

    // Decoded instruction from the instruction buffer
    typedef struct packed {
        logic                             valid;
        logic [`PC_W-1:0]                 pc;
        logic [`OP_W-1:0]                 op;
        logic                             is_load;
        logic                             is_store;
        logic [1:0][`GPR_ADDR_W-1:0]      rs_addr;
        logic [1:0]                       rs_valid;
        logic [`GPR_ADDR_W-1:0]           rd_addr;
        logic                             rd_valid;
        logic                             use_imm;
        logic [`DATA_W-1:0]               imm;
    } id_slot_t;

    // Issued instruction toward execute
    typedef struct packed {
        logic                             valid;
        logic [`PC_W-1:0]                 pc;
        logic [`OP_W-1:0]                 op;
        logic [`DATA_W-1:0]               src1;
        logic [`DATA_W-1:0]               src2;
        logic [`GPR_ADDR_W-1:0]           rd_addr;
        logic                             rd_valid;
        logic                             is_load;
    } exe_slot_t;

    // One result leaving a pipeline stage
    typedef struct packed {
        logic                             wr;
        logic [`GPR_ADDR_W-1:0]           addr;
        logic [`DATA_W-1:0]               data;
        logic                             data_valid;
    } fwd_entry_t;

endpackage

// ==== include/dispatch_cfg.svh ====
`ifndef DISPATCH_CFG_SVH
`define DISPATCH_CFG_SVH

// Issue slots per cycle
`define DISP_WIDTH 2

// General register file
`define GPR_NUM 32
`define GPR_ADDR_W 5

// Operand and immediate width
`define DATA_W 32

// ALU operation code
`define OP_W 8

// Program counter
`define PC_W 32

`endif
